/* design/weight_fmt_pkg.sv */
`default_nettype none

package weight_fmt_pkg;

    // ------------------------------------------------------------------------
    // bus and RAM geometry
    // ------------------------------------------------------------------------
    localparam int BEAT_W    = 128;
    localparam int WORD_W    = 288;
    localparam int TAP_W     = 32;
    localparam int NUM_TAPS  = WORD_W / TAP_W;
    localparam int PAD_W     = WORD_W - 2 * BEAT_W;
    localparam int NUM_BANKS = 16;
    localparam int ADDR_W    = 8;
    localparam int CNT_W     = 11;

    // four banks share one word of a depthwise block
    localparam int NUM_GROUPS      = 4;
    localparam int BANKS_PER_GROUP = NUM_BANKS / NUM_GROUPS;

    typedef logic [BEAT_W-1:0] beat_t;

    // one RAM word, seen as nine taps or as two beats plus pad
    typedef union packed {
        logic [NUM_TAPS-1:0][TAP_W-1:0] taps;
        struct packed {
            logic [PAD_W-1:0] pad;
            beat_t            hi;
            beat_t            lo;
        } pair;
    } weight_word_t;

    // bank i takes word i / BANKS_PER_GROUP
    typedef weight_word_t [NUM_GROUPS-1:0] word_group_t;

endpackage

`default_nettype wire

/* design/net_cfg_pkg.sv */
`default_nettype none

package net_cfg_pkg;

    typedef enum logic [1:0] {
        L_CONV = 2'd0,
        L_DW   = 2'd1,
        L_PW   = 2'd2,
        L_IDLE = 2'd3
    } layer_type_e;

    // ------------------------------------------------------------------------
    // network table, first ten layers only
    // ------------------------------------------------------------------------
    localparam int NUM_LAYERS  = 10;
    localparam int LAYER_IDX_W = 4;

    // shortcut pointwise layers count as plain pointwise
    localparam layer_type_e LAYER_TYPE [NUM_LAYERS] = '{
        L_CONV, L_DW, L_PW, L_PW, L_DW,
        L_PW,   L_PW, L_DW, L_PW, L_PW
    };

    // channel count at the input of each layer, entry n+1 is the output of n
    localparam int unsigned C_SIZE [NUM_LAYERS+1] = '{
        3, 32, 32, 16, 96, 96, 24, 144, 144, 24, 144
    };

    // beat grouping per layer type
    localparam int CONV_TAP_BEATS  = 3;
    localparam int CONV_ROWS       = 3;
    localparam int CONV_BANKS_USED = 16;
    localparam int CONV_PASSES     = 2;
    localparam int DW_BEATS        = 9;
    localparam int PW_BEATS        = 2;

endpackage

`default_nettype wire

/* design/weight_gather_if.sv */
`default_nettype none

// one write request from a gatherer towards the RAM writer
interface weight_gather_if import weight_fmt_pkg::*; ();

    logic                 wr_stb;
    logic [NUM_BANKS-1:0] bank_sel;
    logic [ADDR_W-1:0]    addr;
    word_group_t          data;

    modport gatherer (
        output wr_stb, bank_sel, addr, data
    );

    modport writer (
        input wr_stb, bank_sel, addr, data
    );

endinterface

`default_nettype wire

/* design/layer_sequencer.sv */
`default_nettype none

module layer_sequencer
    import weight_fmt_pkg::*;
    import net_cfg_pkg::*;
(
    input  wire logic             clk_200M,
    input  wire logic             rst_n,
    input  wire logic [2:0]       layer_done_i,
    output layer_type_e           layer_type_o,
    output logic      [CNT_W-1:0] c_in_o,
    output logic      [CNT_W-1:0] c_out_o,
    output logic      [CNT_W-1:0] w_change_ctrl_o
);

    logic [LAYER_IDX_W-1:0] layer_idx;
    logic                   idle;

    assign idle = (layer_idx >= NUM_LAYERS);

    // advance on the edge that takes the last beat of a layer
    always_ff @(posedge clk_200M or negedge rst_n) begin
        if (!rst_n) begin
            layer_idx <= '0;
        end else if (|layer_done_i) begin
            layer_idx <= layer_idx + 1'b1;
        end
    end

    // table lookup
    always_comb begin
        if (idle) begin
            layer_type_o = L_IDLE;
            c_in_o       = '0;
            c_out_o      = '0;
        end else begin
            layer_type_o = LAYER_TYPE[layer_idx];
            c_in_o       = CNT_W'(C_SIZE[layer_idx]);
            c_out_o      = CNT_W'(C_SIZE[layer_idx + 1]);
        end
    end

    // ------------------------------------------------------------------------
    // RAM change count one cycle behind the layer
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_200M or negedge rst_n) begin
        if (!rst_n) begin
            w_change_ctrl_o <= '0;
        end else begin
            case (layer_type_o)
                L_CONV:  w_change_ctrl_o <= CNT_W'(2);
                L_DW:    w_change_ctrl_o <= '0;
                L_PW:    w_change_ctrl_o <= (c_in_o >> 3) - 1'b1;
                default: w_change_ctrl_o <= w_change_ctrl_o;
            endcase
        end
    end

    a_idx_range: assert property (@(posedge clk_200M) disable iff (!rst_n)
        layer_idx <= NUM_LAYERS)
        else $error("layer index past end of table");

    // only the active gatherer may finish a layer
    a_one_done: assert property (@(posedge clk_200M) disable iff (!rst_n)
        $onehot0(layer_done_i))
        else $error("more than one gatherer reported layer done");

endmodule

`default_nettype wire

/* design/conv_weight_gather.sv */
`default_nettype none

module conv_weight_gather
    import weight_fmt_pkg::*;
    import net_cfg_pkg::*;
(
    input  wire logic        clk_200M,
    input  wire logic        rst_n,
    input  wire logic        active_i,
    input  wire logic        w_in_vld_i,
    input  wire beat_t       w_in_i,
    weight_gather_if.gatherer req,
    output logic             layer_done_o
);

    logic [$clog2(CONV_TAP_BEATS)-1:0]  tap_cnt;
    logic [$clog2(CONV_ROWS)-1:0]       row_cnt;
    logic [$clog2(CONV_BANKS_USED)-1:0] bank_cnt;
    logic [$clog2(CONV_PASSES)-1:0]     pass_cnt;
    logic                               beat;
    logic                               tap_last;
    logic                               row_last;
    logic                               bank_last;
    logic                               pass_last;
    beat_t [1:0]                        cache_q;
    weight_word_t                       word;

    assign beat      = active_i && w_in_vld_i;
    assign tap_last  = (tap_cnt == CONV_TAP_BEATS - 1);
    assign row_last  = (row_cnt == CONV_ROWS - 1);
    assign bank_last = (bank_cnt == CONV_BANKS_USED - 1);
    assign pass_last = (pass_cnt == CONV_PASSES - 1);

    // ------------------------------------------------------------------------
    // nested counters for tap beat, row, bank and pass
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_200M or negedge rst_n) begin
        if (!rst_n) begin
            tap_cnt  <= '0;
            row_cnt  <= '0;
            bank_cnt <= '0;
            pass_cnt <= '0;
        end else if (beat) begin
            tap_cnt <= tap_last ? '0 : tap_cnt + 1'b1;
            if (tap_last) begin
                row_cnt <= row_last ? '0 : row_cnt + 1'b1;
                if (row_last) begin
                    bank_cnt <= bank_last ? '0 : bank_cnt + 1'b1;
                    if (bank_last) begin
                        pass_cnt <= pass_last ? '0 : pass_cnt + 1'b1;
                    end
                end
            end
        end
    end

    // newest beat enters at the top
    always_ff @(posedge clk_200M) begin
        if (beat) begin
            cache_q <= {w_in_i, cache_q[1]};
        end
    end

    // tap 8 is the low lane of the third beat
    assign word.taps = {w_in_i[TAP_W-1:0], cache_q};

    assign req.wr_stb   = beat && tap_last;
    assign req.bank_sel = NUM_BANKS'(1) << bank_cnt;
    assign req.addr     = ADDR_W'(row_cnt);
    assign req.data     = {NUM_GROUPS{word}};

    assign layer_done_o = beat && tap_last && row_last && bank_last && pass_last;

    // the sequencer leaves the conv layer only after its last beat
    a_conv_whole_layer: assert property (@(posedge clk_200M) disable iff (!rst_n)
        $fell(active_i) |-> $past(layer_done_o))
        else $error("conv layer left before its last beat");

endmodule

`default_nettype wire

/* design/dw_weight_gather.sv */
`default_nettype none

module dw_weight_gather
    import weight_fmt_pkg::*;
    import net_cfg_pkg::*;
(
    input  wire logic             clk_200M,
    input  wire logic             rst_n,
    input  wire logic             active_i,
    input  wire logic             w_in_vld_i,
    input  wire beat_t            w_in_i,
    input  wire logic [CNT_W-1:0] c_in_i,
    weight_gather_if.gatherer     req,
    output logic                  layer_done_o
);

    logic [$clog2(DW_BEATS)-1:0]   beat_cnt;
    logic [CNT_W-1:0]              grp_cnt;
    logic [CNT_W-1:0]              grp_max;
    logic                          beat;
    logic                          beat_last;
    logic                          grp_last;
    beat_t [DW_BEATS-2:0]          cache_q;
    logic [DW_BEATS*BEAT_W-1:0]    block;

    assign beat      = active_i && w_in_vld_i;
    assign grp_max   = (c_in_i >> 2) - 1'b1;
    assign beat_last = (beat_cnt == DW_BEATS - 1);
    assign grp_last  = (grp_cnt == grp_max);

    always_ff @(posedge clk_200M or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            grp_cnt  <= '0;
        end else if (beat) begin
            beat_cnt <= beat_last ? '0 : beat_cnt + 1'b1;
            if (beat_last) begin
                grp_cnt <= grp_last ? '0 : grp_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_200M) begin
        if (beat) begin
            cache_q <= {w_in_i, cache_q[DW_BEATS-2:1]};
        end
    end

    // 1152-bit block, first beat lowest
    assign block = {w_in_i, cache_q};

    always_comb begin
        for (int g = 0; g < NUM_GROUPS; g++) begin
            req.data[g].taps = block[g*WORD_W +: WORD_W];
        end
    end

    assign req.wr_stb   = beat && beat_last;
    assign req.bank_sel = '1;
    assign req.addr     = '0;

    assign layer_done_o = beat && beat_last && grp_last;

endmodule

`default_nettype wire

/* design/pw_weight_gather.sv */
`default_nettype none

module pw_weight_gather
    import weight_fmt_pkg::*;
    import net_cfg_pkg::*;
(
    input  wire logic             clk_200M,
    input  wire logic             rst_n,
    input  wire logic             active_i,
    input  wire logic             w_in_vld_i,
    input  wire beat_t            w_in_i,
    input  wire logic [CNT_W-1:0] c_in_i,
    input  wire logic [CNT_W-1:0] c_out_i,
    weight_gather_if.gatherer     req,
    output logic                  layer_done_o
);

    logic [$clog2(PW_BEATS)-1:0] pair_cnt;
    logic [CNT_W-1:0]            in_cnt;
    logic [CNT_W-1:0]            out_cnt;
    logic [CNT_W-1:0]            in_max;
    logic [CNT_W-1:0]            out_max;
    logic                        beat;
    logic                        pair_last;
    logic                        in_last;
    logic                        out_last;
    beat_t                       cache_q;
    weight_word_t                word;

    // eight inputs per write, sixteen outputs per input sweep
    assign in_max    = (c_in_i >> 3) - 1'b1;
    assign out_max   = (c_out_i >> 4) - 1'b1;
    assign beat      = active_i && w_in_vld_i;
    assign pair_last = (pair_cnt == PW_BEATS - 1);
    assign in_last   = (in_cnt == in_max);
    assign out_last  = (out_cnt == out_max);

    // ------------------------------------------------------------------------
    // pair, input group and output group counters
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_200M or negedge rst_n) begin
        if (!rst_n) begin
            pair_cnt <= '0;
            in_cnt   <= '0;
            out_cnt  <= '0;
        end else if (beat) begin
            pair_cnt <= pair_last ? '0 : pair_cnt + 1'b1;
            if (pair_last) begin
                in_cnt <= in_last ? '0 : in_cnt + 1'b1;
                if (in_last) begin
                    out_cnt <= out_last ? '0 : out_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_200M) begin
        if (beat) begin
            cache_q <= w_in_i;
        end
    end

    // zero pad on top of the two beats
    always_comb begin
        word.pair.pad = '0;
        word.pair.hi  = w_in_i;
        word.pair.lo  = cache_q;
    end

    assign req.wr_stb   = beat && pair_last;
    assign req.bank_sel = '1;
    assign req.addr     = ADDR_W'(in_cnt);
    assign req.data     = {NUM_GROUPS{word}};

    assign layer_done_o = beat && pair_last && in_last && out_last;

endmodule

`default_nettype wire

/* design/weight_ram_writer.sv */
`default_nettype none

module weight_ram_writer
    import weight_fmt_pkg::*;
(
    input  wire logic                        clk_200M,
    input  wire logic                        rst_n,
    weight_gather_if.writer                  conv_req_i,
    weight_gather_if.writer                  dw_req_i,
    weight_gather_if.writer                  pw_req_i,
    output logic [NUM_BANKS-1:0]             ram_w_wr_en_o,
    output logic [ADDR_W-1:0]                ram_w_wr_addr_o,
    output logic [NUM_BANKS*WORD_W-1:0]      ram_w_wr_data_all_o
);

    logic                            sel_stb;
    logic [NUM_BANKS-1:0]            sel_bank;
    logic [ADDR_W-1:0]               sel_addr;
    word_group_t                     sel_data;
    weight_word_t [NUM_BANKS-1:0]    data_q;

    // ------------------------------------------------------------------------
    // pick the requesting gatherer
    // ------------------------------------------------------------------------
    always_comb begin
        sel_stb = conv_req_i.wr_stb | dw_req_i.wr_stb | pw_req_i.wr_stb;
        if (conv_req_i.wr_stb) begin
            sel_bank = conv_req_i.bank_sel;
            sel_addr = conv_req_i.addr;
            sel_data = conv_req_i.data;
        end else if (dw_req_i.wr_stb) begin
            sel_bank = dw_req_i.bank_sel;
            sel_addr = dw_req_i.addr;
            sel_data = dw_req_i.data;
        end else begin
            sel_bank = pw_req_i.bank_sel;
            sel_addr = pw_req_i.addr;
            sel_data = pw_req_i.data;
        end
    end

    always_ff @(posedge clk_200M or negedge rst_n) begin
        if (!rst_n) begin
            ram_w_wr_en_o   <= '0;
            ram_w_wr_addr_o <= '0;
        end else begin
            ram_w_wr_en_o <= sel_stb ? sel_bank : '0;
            // address holds between writes
            if (sel_stb) begin
                ram_w_wr_addr_o <= sel_addr;
            end
        end
    end

    // per-bank data, zero outside a write
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        always_ff @(posedge clk_200M or negedge rst_n) begin
            if (!rst_n) begin
                data_q[b] <= '0;
            end else if (sel_stb && sel_bank[b]) begin
                data_q[b] <= sel_data[b / BANKS_PER_GROUP];
            end else begin
                data_q[b] <= '0;
            end
        end
    end

    assign ram_w_wr_data_all_o = data_q;

    a_one_req: assert property (@(posedge clk_200M) disable iff (!rst_n)
        $onehot0({conv_req_i.wr_stb, dw_req_i.wr_stb, pw_req_i.wr_stb}))
        else $error("two gatherers requested a write in one cycle");

endmodule

`default_nettype wire

/* design/w_ctrl.sv */
`default_nettype none

module w_ctrl
    import weight_fmt_pkg::*;
    import net_cfg_pkg::*;
(
    input  wire logic                        clk_200M,
    input  wire logic                        rst_n,
    input  wire logic                        w_in_vld_i,
    input  wire logic [BEAT_W-1:0]           w_in_i,
    output logic [NUM_BANKS-1:0]             ram_w_wr_en_o,
    output logic [ADDR_W-1:0]                ram_w_wr_addr_o,
    output logic [NUM_BANKS*WORD_W-1:0]      ram_w_wr_data_all_o,
    output logic [CNT_W-1:0]                 w_change_ctrl_o
);

    layer_type_e      layer_type;
    logic [CNT_W-1:0] c_in;
    logic [CNT_W-1:0] c_out;
    logic             conv_done;
    logic             dw_done;
    logic             pw_done;

    weight_gather_if conv_req ();
    weight_gather_if dw_req ();
    weight_gather_if pw_req ();

    // ------------------------------------------------------------------------
    // layer control
    // ------------------------------------------------------------------------
    layer_sequencer seq_i (
        .clk_200M        (clk_200M),
        .rst_n           (rst_n),
        .layer_done_i    ({pw_done, dw_done, conv_done}),
        .layer_type_o    (layer_type),
        .c_in_o          (c_in),
        .c_out_o         (c_out),
        .w_change_ctrl_o (w_change_ctrl_o)
    );

    // ------------------------------------------------------------------------
    // gatherers, one per layer type
    // ------------------------------------------------------------------------
    conv_weight_gather conv_i (
        .clk_200M     (clk_200M),
        .rst_n        (rst_n),
        .active_i     (layer_type == L_CONV),
        .w_in_vld_i   (w_in_vld_i),
        .w_in_i       (w_in_i),
        .req          (conv_req.gatherer),
        .layer_done_o (conv_done)
    );

    dw_weight_gather dw_i (
        .clk_200M     (clk_200M),
        .rst_n        (rst_n),
        .active_i     (layer_type == L_DW),
        .w_in_vld_i   (w_in_vld_i),
        .w_in_i       (w_in_i),
        .c_in_i       (c_in),
        .req          (dw_req.gatherer),
        .layer_done_o (dw_done)
    );

    pw_weight_gather pw_i (
        .clk_200M     (clk_200M),
        .rst_n        (rst_n),
        .active_i     (layer_type == L_PW),
        .w_in_vld_i   (w_in_vld_i),
        .w_in_i       (w_in_i),
        .c_in_i       (c_in),
        .c_out_i      (c_out),
        .req          (pw_req.gatherer),
        .layer_done_o (pw_done)
    );

    weight_ram_writer writer_i (
        .clk_200M            (clk_200M),
        .rst_n               (rst_n),
        .conv_req_i          (conv_req.writer),
        .dw_req_i            (dw_req.writer),
        .pw_req_i            (pw_req.writer),
        .ram_w_wr_en_o       (ram_w_wr_en_o),
        .ram_w_wr_addr_o     (ram_w_wr_addr_o),
        .ram_w_wr_data_all_o (ram_w_wr_data_all_o)
    );

endmodule

`default_nettype wire

/* bench/w_ctrl_checker.sv */
`default_nettype none

module w_ctrl_checker
    import weight_fmt_pkg::*;
    import net_cfg_pkg::*;
(
    input  wire logic                        clk_200M,
    input  wire logic                        rst_n,
    input  wire logic                        w_in_vld_i,
    input  wire beat_t                       w_in_i,
    input  wire logic [NUM_BANKS-1:0]        wr_en_i,
    input  wire logic [ADDR_W-1:0]           wr_addr_i,
    input  wire logic [NUM_BANKS*WORD_W-1:0] wr_data_i,
    input  wire logic [CNT_W-1:0]            change_i,
    output int                               errors_o
);

    typedef struct packed {
        logic [NUM_BANKS-1:0]        en;
        logic [ADDR_W-1:0]           addr;
        logic [NUM_BANKS*WORD_W-1:0] data;
    } wr_t;

    int                   layer_idx;
    int                   beat_pos;
    int                   write_cnt;
    int                   obs_writes [NUM_LAYERS];
    beat_t [DW_BEATS-1:0] blk_q;
    wr_t                  pend;
    int                   pend_layer;
    logic                 pend_last;
    string                pend_test;
    logic [CNT_W-1:0]     exp_change;
    logic [ADDR_W-1:0]    last_addr;

    initial errors_o = 0;

    // ------------------------------------------------------------------------
    // layer rules
    // ------------------------------------------------------------------------
    function automatic int group_beats(layer_type_e lt);
        case (lt)
            L_CONV:  return CONV_TAP_BEATS;
            L_DW:    return DW_BEATS;
            default: return PW_BEATS;
        endcase
    endfunction

    function automatic int layer_writes(int l);
        case (LAYER_TYPE[l])
            L_CONV:  return CONV_ROWS * CONV_BANKS_USED * CONV_PASSES;
            L_DW:    return C_SIZE[l] / 4;
            default: return (C_SIZE[l] / 8) * (C_SIZE[l+1] / 16);
        endcase
    endfunction

    function automatic int change_rule(int l);
        case (LAYER_TYPE[l])
            L_CONV:  return 2;
            L_DW:    return 0;
            default: return C_SIZE[l] / 8 - 1;
        endcase
    endfunction

    function automatic string type_name(layer_type_e lt);
        case (lt)
            L_CONV:  return "conv layer";
            L_DW:    return "depthwise layer";
            default: return "pointwise layer";
        endcase
    endfunction

    // expected write for the beat at position pos of its group
    function automatic wr_t expected_write(layer_type_e lt, int pos, int bank, int row,
            int in_grp, beat_t [DW_BEATS-1:0] blk, logic [ADDR_W-1:0] hold_addr);
        wr_t                         w;
        logic [WORD_W-1:0]           word;
        logic [DW_BEATS*BEAT_W-1:0]  block;
        logic [NUM_BANKS*WORD_W-1:0] data;
        w.en   = '0;
        w.addr = hold_addr;
        data   = '0;
        if (lt == L_CONV && pos == CONV_TAP_BEATS - 1) begin
            // tap 0 is lane 0 of the first beat
            word = {blk[2][TAP_W-1:0], blk[1], blk[0]};
            w.en = NUM_BANKS'(1) << bank;
            w.addr = ADDR_W'(row);
            data[bank*WORD_W +: WORD_W] = word;
        end else if (lt == L_DW && pos == DW_BEATS - 1) begin
            block = blk;
            w.en = '1;
            w.addr = '0;
            for (int b = 0; b < NUM_BANKS; b++) begin
                data[b*WORD_W +: WORD_W] = block[(b/4)*WORD_W +: WORD_W];
            end
        end else if (lt == L_PW && pos == PW_BEATS - 1) begin
            word = {{PAD_W{1'b0}}, blk[1], blk[0]};
            w.en = '1;
            w.addr = ADDR_W'(in_grp);
            for (int b = 0; b < NUM_BANKS; b++) begin
                data[b*WORD_W +: WORD_W] = word;
            end
        end
        w.data = data;
        return w;
    endfunction

    task automatic report_mismatch(string test, string what, logic [WORD_W-1:0] exp_v,
            logic [WORD_W-1:0] act_v);
        $display("MISMATCH %s %s at %0t: expected %0h actual %0h",
            test, what, $time, exp_v, act_v);
        errors_o++;
    endtask

    // ------------------------------------------------------------------------
    // comparison of the DUT outputs against the pending expectation
    // ------------------------------------------------------------------------
    task automatic compare_outputs();
        logic                        found;
        logic [NUM_BANKS*WORD_W-1:0] exp_data;
        found    = 1'b0;
        exp_data = pend.data;
        if (wr_en_i !== pend.en)
            report_mismatch(pend_test, "enables", WORD_W'(pend.en), WORD_W'(wr_en_i));
        if (wr_addr_i !== pend.addr)
            report_mismatch(pend_test, "address", WORD_W'(pend.addr), WORD_W'(wr_addr_i));
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (!found && wr_data_i[b*WORD_W +: WORD_W] !== exp_data[b*WORD_W +: WORD_W]) begin
                found = 1'b1;
                report_mismatch(pend_test, $sformatf("bank %0d data", b),
                    exp_data[b*WORD_W +: WORD_W], wr_data_i[b*WORD_W +: WORD_W]);
            end
        end
        if (change_i !== exp_change)
            report_mismatch("change count", "w_change_ctrl", WORD_W'(exp_change),
                WORD_W'(change_i));
    endtask

    // writes seen per layer and checked after the layer's last write
    task automatic count_writes();
        if (wr_en_i != '0 && pend_layer < NUM_LAYERS)
            obs_writes[pend_layer]++;
        if (pend_last && obs_writes[pend_layer] != layer_writes(pend_layer))
            report_mismatch(type_name(LAYER_TYPE[pend_layer]), "write count",
                WORD_W'(layer_writes(pend_layer)), WORD_W'(obs_writes[pend_layer]));
    endtask

    task automatic step_model();
        layer_type_e lt;
        int          row;
        int          bank;
        int          in_grp;
        pend_layer = layer_idx;
        pend_last  = 1'b0;
        pend_test  = "quiet outputs";
        pend.en    = '0;
        pend.data  = '0;
        pend.addr  = last_addr;
        // change count holds once the table is done
        if (layer_idx < NUM_LAYERS)
            exp_change = CNT_W'(change_rule(layer_idx));
        if (w_in_vld_i && layer_idx < NUM_LAYERS) begin
            lt = LAYER_TYPE[layer_idx];
            blk_q[beat_pos] = w_in_i;
            row  = write_cnt % CONV_ROWS;
            bank = (write_cnt / CONV_ROWS) % CONV_BANKS_USED;
            in_grp = 0;
            if (lt == L_PW)
                in_grp = write_cnt % (C_SIZE[layer_idx] / 8);
            pend = expected_write(lt, beat_pos, bank, row, in_grp, blk_q, last_addr);
            if (pend.en != '0) begin
                pend_test = type_name(lt);
                last_addr = pend.addr;
            end
            beat_pos++;
            if (beat_pos == group_beats(lt)) begin
                beat_pos = 0;
                write_cnt++;
                if (write_cnt == layer_writes(layer_idx)) begin
                    write_cnt = 0;
                    pend_last = 1'b1;
                    layer_idx++;
                end
            end
        end
    endtask

    task automatic reset_model();
        layer_idx  = 0;
        beat_pos   = 0;
        write_cnt  = 0;
        pend       = '0;
        pend_layer = 0;
        pend_last  = 1'b0;
        pend_test  = "reset";
        exp_change = '0;
        last_addr  = '0;
        for (int l = 0; l < NUM_LAYERS; l++) begin
            obs_writes[l] = 0;
        end
    endtask

    // inputs and outputs are both settled at the falling edge
    always @(negedge clk_200M) begin
        if (rst_n !== 1'b1) begin
            reset_model();
        end else begin
            compare_outputs();
            count_writes();
            step_model();
        end
    end

endmodule

`default_nettype wire

/* bench/tb_w_ctrl.sv */
`default_nettype none

module tb_w_ctrl
    import weight_fmt_pkg::*;
    import net_cfg_pkg::*;
();

    localparam int WRITE_TIMEOUT = 50;
    localparam int EXTRA_BEATS   = 20;
    localparam int MAX_GAP       = 4;

    logic                        clk_200M;
    logic                        rst_n;
    logic                        w_in_vld_i;
    beat_t                       w_in_i;
    logic [NUM_BANKS-1:0]        ram_w_wr_en_o;
    logic [ADDR_W-1:0]           ram_w_wr_addr_o;
    logic [NUM_BANKS*WORD_W-1:0] ram_w_wr_data_all_o;
    logic [CNT_W-1:0]            w_change_ctrl_o;
    int                          chk_errors;
    int                          seed;
    int                          wait_cycles;

    w_ctrl w_ctrl_i (
        .clk_200M            (clk_200M),
        .rst_n               (rst_n),
        .w_in_vld_i          (w_in_vld_i),
        .w_in_i              (w_in_i),
        .ram_w_wr_en_o       (ram_w_wr_en_o),
        .ram_w_wr_addr_o     (ram_w_wr_addr_o),
        .ram_w_wr_data_all_o (ram_w_wr_data_all_o),
        .w_change_ctrl_o     (w_change_ctrl_o)
    );

    w_ctrl_checker chk_i (
        .clk_200M   (clk_200M),
        .rst_n      (rst_n),
        .w_in_vld_i (w_in_vld_i),
        .w_in_i     (w_in_i),
        .wr_en_i    (ram_w_wr_en_o),
        .wr_addr_i  (ram_w_wr_addr_o),
        .wr_data_i  (ram_w_wr_data_all_o),
        .change_i   (w_change_ctrl_o),
        .errors_o   (chk_errors)
    );

    initial begin
        clk_200M = 1'b0;
        forever #10 clk_200M = ~clk_200M;
    end

    // beats per layer from the grouping rules
    function automatic int layer_beats(int l);
        case (LAYER_TYPE[l])
            L_CONV:  return CONV_TAP_BEATS * CONV_ROWS * CONV_BANKS_USED * CONV_PASSES;
            L_DW:    return DW_BEATS * (C_SIZE[l] / 4);
            default: return PW_BEATS * (C_SIZE[l] / 8) * (C_SIZE[l+1] / 16);
        endcase
    endfunction

    function automatic beat_t random_beat();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // random gap with junk data then one valid beat
    task automatic send_beat();
        int gap;
        gap = $unsigned($random(seed)) % MAX_GAP;
        for (int g = 0; g < gap; g++) begin
            w_in_vld_i = 1'b0;
            w_in_i     = random_beat();
            @(posedge clk_200M);
            #2;
        end
        w_in_vld_i = 1'b1;
        w_in_i     = random_beat();
        @(posedge clk_200M);
        #2;
        w_in_vld_i = 1'b0;
    endtask

    initial begin
        seed       = 95406;
        rst_n      = 1'b0;
        w_in_vld_i = 1'b0;
        w_in_i     = '0;
        repeat (10) @(posedge clk_200M);
        #2;
        rst_n = 1'b1;

        for (int l = 0; l < NUM_LAYERS; l++) begin
            for (int b = 0; b < layer_beats(l); b++) begin
                send_beat();
            end
        end

        // last pointwise group of the table reaches the RAM port
        wait_cycles = 0;
        while (ram_w_wr_en_o == '0 && wait_cycles < WRITE_TIMEOUT) begin
            @(posedge clk_200M);
            #2;
            wait_cycles++;
        end

        if (ram_w_wr_en_o == '0) begin
            $display("timeout: the last write of the layer table never appeared");
            $display("Finished with errors");
            $finish;
        end else begin
            // beats past the end of the table must leave no trace
            for (int b = 0; b < EXTRA_BEATS; b++) begin
                send_beat();
            end
            repeat (4) @(posedge clk_200M);
            #2;
            $display("checks done: %0d errors", chk_errors);
            if (chk_errors == 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sources.f */
design/weight_fmt_pkg.sv
design/net_cfg_pkg.sv
design/weight_gather_if.sv
design/layer_sequencer.sv
design/conv_weight_gather.sv
design/dw_weight_gather.sv
design/pw_weight_gather.sv
design/weight_ram_writer.sv
design/w_ctrl.sv
bench/w_ctrl_checker.sv
bench/tb_w_ctrl.sv
